// File: bench/zx_port_model.svh
// reference model of the z80 port block
// shadow copy of every port register, expected reads and the stimulus lfsr
`ifndef ZX_PORT_MODEL_SVH
`define ZX_PORT_MODEL_SVH

video_t      m_video;
paging_t     m_paging;
logic        m_lock;      // 7FFD lock
logic        m_shadow_en; // BF bit 0
logic        m_romrw;     // BF bit 1
logic [7:0]  m_sav [4];   // scratch, index addr[6:5]
logic [31:0] lfsr_state = 32'd72363;

function automatic void reset_model();
	m_video     = '0;
	m_paging    = {8'h05, 8'd0, 8'd5, 8'd2, 8'd0, 8'h00, 8'h00}; // vpage, pages, 7ffd, eff7
	m_lock      = 1'b0;
	m_shadow_en = 1'b0;
	m_romrw     = 1'b0;
	foreach (m_sav[k])
		m_sav[k] = 8'h00;
endfunction

function automatic logic shadow_mode();
	return m_shadow_en | dos;
endfunction

function automatic logic scratch_port(input logic [7:0] lo);
	return lo == SAV_BASE || lo == SAV_BASE + 8'h20 || lo == SAV_BASE + 8'h40 ||
		lo == SAV_BASE + 8'h60;
endfunction

////////////////////
// port writes
////////////////////

function automatic void apply_write(input logic [15:0] addr, input logic [7:0] d);
	logic [7:0] lo;
	logic       b1m;
	logic       sh;
	lo  = addr[7:0];
	b1m = m_paging.peff7_raw[2]; // 128k compatible mode
	sh  = shadow_mode();
	if (lo == PORT_FE)
		m_video.border = {d[7], d[2:0]};
	if (lo == PORT_XT)
	begin
		case (addr[15:8])
		XT_VCONFIG:  m_video.vconfig = d;
		XT_FMADDR:   m_video.fmaddr = d[4:0];
		XT_XOFFS_L:  m_video.x_offs[7:0] = d;
		XT_XOFFS_H:  m_video.x_offs[8] = d[0]; // top bit of 9
		XT_YOFFS_L:  m_video.y_offs[7:0] = d;
		XT_YOFFS_H:  m_video.y_offs[8] = d[0];
		XT_VPAGE:    m_paging.vpage = d;
		XT_RAMPAGE0: m_paging.rampage0 = d;
		XT_RAMPAGE1: m_paging.rampage1 = d;
		XT_RAMPAGE2: m_paging.rampage2 = d;
		XT_RAMPAGE3: m_paging.rampage3 = d;
		default: ; // unused numbers change nothing
		endcase
	end
	if (lo == PORT_FD && !addr[15] && !m_lock)
	begin
		m_paging.p7ffd    = d;
		m_lock            = d[5] & b1m;
		m_paging.rampage3 = {2'b00, (b1m ? 3'b000 : {d[5], d[7], d[6]}), d[2:0]};
		m_paging.vpage    = 8'h04 + (d[3] ? 8'h02 : 8'h00) + 8'h01;
	end
	if (lo == PORT_F7 && !sh && addr[8] && !addr[12])
		m_paging.peff7_raw = d;
	if (lo == PORT_BF)
	begin
		m_shadow_en = d[0];
		m_romrw     = d[1];
	end
	if (scratch_port(lo) && sh)
		m_sav[addr[6:5]] = d;
endfunction

////////////////////
// port reads
////////////////////

function automatic logic [7:0] expected_read(input logic [15:0] addr, input logic [4:0] keys,
	input logic tape);
	logic [7:0] lo;
	logic [7:0] r;
	lo = addr[7:0];
	r  = 8'hFF; // nothing decoded
	if (lo == PORT_FE)
		r = {1'b1, tape, 1'b0, keys};
	else if (lo == PORT_BF)
		r = {6'd0, m_romrw, m_shadow_en};
	else if (scratch_port(lo) && shadow_mode())
		r = m_sav[addr[6:5]];
	else if (lo == PORT_BE)
	begin
		case (addr[11:8])
		4'h0: r = m_paging.rampage0;
		4'h1: r = m_paging.rampage1;
		4'h2: r = m_paging.rampage2;
		4'h3: r = m_paging.rampage3;
		4'h4: r = m_paging.vpage;
		4'hA: r = m_paging.p7ffd;
		4'hB: r = m_paging.peff7_raw;
		default: r = 8'hFF;
		endcase
	end
	return r;
endfunction

function automatic logic port_hit(input logic [15:0] addr);
	logic hit;
	case (addr[7:0])
	PORT_FE, PORT_XT, PORT_BE, PORT_BF, PORT_FD: hit = 1'b1;
	PORT_F7: hit = !shadow_mode(); // any high byte
	default: hit = scratch_port(addr[7:0]) && shadow_mode();
	endcase
	return hit;
endfunction

function automatic logic [7:0] masked_peff7();
	// block1m clears bits 6, 3, 2, 1
	return m_paging.peff7_raw[2] ? (m_paging.peff7_raw & 8'hB1) : m_paging.peff7_raw;
endfunction

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [7:0] rand_bits(input int n);
	logic [7:0] r;
	int         i;
	r = 8'h00;
	for (i = 0; i < n; i++)
	begin
		r[i]       = lfsr_state[0]; // one step per bit
		lfsr_state = lfsr_step(lfsr_state);
	end
	return r;
endfunction

`endif

// File: bench/zx_port_block_tb.sv
// testbench for the z80 i/o port block
// bus cycles against a reference model, one checker process, watchdog
`timescale 1ns/1ps

module zx_port_block_tb;

	import zx_port_pkg::*;

	localparam int CLK_NS       = 4;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_CLKS   = 6;                  // 4 active + 2 idle
	localparam int BUS_CYCLES   = 8 + 12 + 22 + 8 + 17; // tests 1 to 5
	localparam int WATCHDOG_NS  = (BUS_CYCLES * CYCLE_CLKS + RESET_CYCLES) * CLK_NS * 2;

	logic       zclk;
	logic       rst_n;
	zbus_t      bus;
	logic       dos;
	logic [4:0] keys_in;
	logic       tape_read;
	logic [7:0] dout;
	logic       dataout;
	logic       porthit;
	video_t     video;
	paging_t    paging;
	logic [7:0] peff7;
	logic       pent1m_rom;
	logic       pent1m_1m_on;
	logic       romrw_en;

	string       test_name;
	logic        check_req;  // cleared by the checker when done
	logic        check_read; // read check or register check
	logic [15:0] rd_addr;
	logic [7:0]  rd_dout;
	logic        rd_dataout;
	logic        rd_porthit;
	logic        wr_dataout; // bus drive seen during the last write

	`include "zx_port_model.svh"

	zx_port_block zx_port_block_inst (.*);

	initial
	begin
		zclk = 1'b0;
		forever #(CLK_NS / 2) zclk = ~zclk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: bus cycles did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic expect_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp)
		else
		begin
			$display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	////////////////////
	// bus cycles
	////////////////////

	task automatic bus_idle();
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
	endtask

	task automatic run_check(input logic is_read);
		check_read = is_read;
		check_req  = 1'b1;
		wait (check_req == 1'b0);
	endtask

	// entered and left 1 ns after a rising edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus.addr   = addr;
		bus.din    = data;
		bus.iorq_n = 1'b0;
		bus.wr_n   = 1'b0;
		apply_write(addr, data);
		repeat (3) @(posedge zclk);
		#1;
		wr_dataout = dataout; // last active cycle
		@(posedge zclk);
		#1;
		bus_idle();
		repeat (2) @(posedge zclk);
		#1;
		run_check(1'b0); // registers settled long ago
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus.addr   = addr;
		bus.din    = 8'h00;
		bus.iorq_n = 1'b0;
		bus.rd_n   = 1'b0;
		repeat (3) @(posedge zclk);
		#1;
		rd_addr    = addr; // last active cycle
		rd_dout    = dout;
		rd_dataout = dataout;
		rd_porthit = porthit;
		@(posedge zclk);
		#1;
		bus_idle();
		repeat (2) @(posedge zclk);
		#1;
		run_check(1'b1);
	endtask

	// checker
	initial
	begin
		forever
		begin
			wait (check_req == 1'b1);
			if (check_read)
			begin
				expect_value("dout", expected_read(rd_addr, keys_in, tape_read), rd_dout);
				expect_value("porthit", port_hit(rd_addr), rd_porthit);
				expect_value("dataout", port_hit(rd_addr), rd_dataout);
			end
			else
			begin
				expect_value("video", m_video, video);
				expect_value("paging", m_paging, paging);
				expect_value("peff7", masked_peff7(), peff7);
				expect_value("pent1m_rom", m_paging.p7ffd[4], pent1m_rom);
				expect_value("pent1m_1m_on", !m_paging.peff7_raw[2], pent1m_1m_on);
				expect_value("romrw_en", m_romrw, romrw_en);
				expect_value("dataout on write", 1'b0, wr_dataout);
			end
			check_req = 1'b0;
		end
	end

	////////////////////
	// tests
	////////////////////

	initial
	begin
		logic [7:0] hi;
		logic [7:0] d;
		logic [7:0] locked;
		int         i;
		check_req  = 1'b0;
		check_read = 1'b0;
		wr_dataout = 1'b0;
		test_name  = "reset_values";
		rst_n      = 1'b0;
		dos        = 1'b0;
		keys_in    = 5'd0;
		tape_read  = 1'b0;
		bus.addr   = 16'h0000;
		bus.din    = 8'h00;
		bus_idle();
		reset_model();
		repeat (RESET_CYCLES) @(posedge zclk);
		#1;
		rst_n = 1'b1;

		// reset state and BE readback
		run_check(1'b0);
		for (i = 0; i < 5; i++)
			io_read({4'h0, 4'(i), PORT_BE});
		io_read({8'h0A, PORT_BE});
		io_read({8'h0B, PORT_BE});
		io_read({8'h07, PORT_BE}); // unused index

		// border and keyboard then an undecoded port
		test_name = "port_fe";
		for (i = 0; i < 4; i++)
		begin
			hi = rand_bits(8);
			d  = rand_bits(8);
			io_write({hi, PORT_FE}, d);
			d         = rand_bits(5);
			keys_in   = d[4:0];
			d         = rand_bits(1);
			tape_read = d[0];
			hi        = rand_bits(8);
			io_read({hi, PORT_FE});
			io_read({hi, 8'h33});
		end

		// every xxAF number including unused ones
		test_name = "port_xt";
		for (i = 0; i < 22; i++)
		begin
			d = rand_bits(8);
			io_write({8'(i), PORT_XT}, d);
		end

		// 7FFD then EFF7 mask and lock
		test_name = "paging_7ffd";
		for (i = 0; i < 2; i++)
		begin
			d = rand_bits(8);
			io_write({8'h7F, PORT_FD}, d);
		end
		io_read({8'h0A, PORT_BE});
		test_name = "paging_eff7";
		d = rand_bits(8);
		io_write({8'hEF, PORT_F7}, d | 8'h04); // block1m on
		test_name = "paging_blocked";
		d = rand_bits(8);
		io_write({8'h7F, PORT_FD}, d & 8'hDF);
		test_name = "paging_lock";
		locked = rand_bits(8) | 8'h20;
		io_write({8'h7F, PORT_FD}, locked); // locks now
		io_write({8'h7F, PORT_FD}, ~locked);
		expect_value("7ffd held", locked, paging.p7ffd);
		io_read({8'h0A, PORT_BE});

		// shadow mode and scratch ports
		test_name = "shadow_on";
		d = rand_bits(1);
		io_write({8'h00, PORT_BF}, {6'd0, d[0], 1'b1});
		io_read({8'h00, PORT_BF});
		for (i = 0; i < 4; i++)
		begin
			hi = rand_bits(8);
			d  = rand_bits(8);
			io_write({hi, SAV_BASE + 8'(32 * i)}, d);
		end
		for (i = 0; i < 4; i++)
		begin
			hi = rand_bits(8);
			io_read({hi, SAV_BASE + 8'(32 * i)});
		end
		io_write({8'hEF, PORT_F7}, ~m_paging.peff7_raw); // hidden, no effect
		io_read({8'hEF, PORT_F7});
		test_name = "shadow_off";
		io_write({8'h00, PORT_BF}, 8'h00);
		for (i = 0; i < 4; i++)
			io_read({8'h00, SAV_BASE + 8'(32 * i)});

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: verilog/io_strobe_sync.sv
// i/o strobe generator
// samples the asynchronous z80 iorq/rd/wr and emits one-cycle zclk pulses
`timescale 1ns/1ps

module io_strobe_sync (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zx_port_pkg::zbus_t    bus,
	output zx_port_pkg::strobe_t  strobe
);

	logic iowr; // async write level
	logic iord; // async read level
	logic iowr_q;
	logic iord_q;

	assign iowr = ~(bus.iorq_n | bus.wr_n);
	assign iord = ~(bus.iorq_n | bus.rd_n);

	// rising edge of each level gives the pulse
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			strobe <= '0;
		end
		else
		begin
			iowr_q    <= iowr;
			iord_q    <= iord;
			strobe.wr <= iowr & ~iowr_q; // first sampled edge only
			strobe.rd <= iord & ~iord_q;
		end
	end

	// a z80 cycle is either read or write
	a_strobe_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(strobe.wr && strobe.rd));

	// pulses never stretch, even on long bus cycles
	a_wr_single: assert property (@(posedge zclk) disable iff (!rst_n)
		strobe.wr |=> !strobe.wr);
	a_rd_single: assert property (@(posedge zclk) disable iff (!rst_n)
		strobe.rd |=> !strobe.rd);

endmodule

// File: verilog/paging_regs.sv
// memory paging registers
// spectrum-128 7FFD with lock, pentagon-1m EFF7 and the xxAF page registers
`timescale 1ns/1ps

module paging_regs (
	input  logic                           zclk,
	input  logic                           rst_n,
	input  zx_port_pkg::strobe_t           strobe,
	input  zx_port_pkg::port_sel_e         sel,
	input  logic [zx_port_pkg::ADDR_W-1:0] addr,
	input  logic [zx_port_pkg::DATA_W-1:0] din,
	output zx_port_pkg::paging_t           paging,
	output logic [7:0]                     peff7,
	output logic                           pent1m_rom,
	output logic                           pent1m_1m_on
);

	import zx_port_pkg::*;

	logic    lock;    // 7FFD locked until reset
	logic    block1m; // eff7 bit 2, 128k compatible mode
	xt_reg_e xt_idx;

	assign block1m = paging.peff7_raw[2];
	assign xt_idx  = xt_reg_e'(addr[15:8]);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			paging.vpage     <= 8'h05;
			paging.rampage0  <= 8'd0;
			paging.rampage1  <= 8'd5;
			paging.rampage2  <= 8'd2;
			paging.rampage3  <= 8'd0;
			paging.p7ffd     <= 8'h00;
			paging.peff7_raw <= 8'h00;
			lock             <= 1'b0;
		end
		else if (strobe.wr)
		begin
			case (sel)
			SEL_7FFD:
			begin
				if (!lock)
				begin
					paging.p7ffd    <= din;
					lock            <= din[5] & block1m;
					// extra 1m page bits only when not blocked
					paging.rampage3 <= {2'b00, block1m ? 3'b000 : {din[5], din[7:6]},
						din[2:0]};
					paging.vpage    <= {6'b000001, din[3], 1'b1}; // screen 5 or 7
				end
			end
			SEL_EFF7: paging.peff7_raw <= din;
			SEL_XT:
			begin
				case (xt_idx)
				XT_VPAGE:    paging.vpage    <= din;
				XT_RAMPAGE0: paging.rampage0 <= din;
				XT_RAMPAGE1: paging.rampage1 <= din;
				XT_RAMPAGE2: paging.rampage2 <= din;
				XT_RAMPAGE3: paging.rampage3 <= din;
				default: ; // video sub-registers
				endcase
			end
			default: ;
			endcase
		end
	end

	// 1m blocked hides the pentagon extras
	assign peff7 = block1m ? {paging.peff7_raw[7], 1'b0, paging.peff7_raw[5:4], 3'b000,
		paging.peff7_raw[0]} : paging.peff7_raw;

	assign pent1m_rom   = paging.p7ffd[4];
	assign pent1m_1m_on = ~block1m;

	// only reset opens a locked 7FFD
	a_lock_sticky: assert property (@(posedge zclk) disable iff (!rst_n)
		lock |=> lock);

endmodule

// File: verilog/port_decoder.sv
// port address decoder
// maps the z80 address and shadow mode to a port select and porthit
`timescale 1ns/1ps

module port_decoder (
	input  logic [zx_port_pkg::ADDR_W-1:0] addr,
	input  logic                           shadow,
	output zx_port_pkg::port_sel_e         sel,
	output logic                           porthit
);

	import zx_port_pkg::*;

	logic [7:0] lo; // low byte selects the port

	assign lo = addr[7:0];

	always_comb
	begin
		sel     = SEL_NONE;
		porthit = 1'b0;
		case (lo)
		PORT_FE:
		begin
			sel     = SEL_FE;
			porthit = 1'b1;
		end
		PORT_XT:
		begin
			sel     = SEL_XT;
			porthit = 1'b1;
		end
		PORT_BE:
		begin
			sel     = SEL_BE;
			porthit = 1'b1;
		end
		PORT_BF:
		begin
			sel     = SEL_BF;
			porthit = 1'b1;
		end
		PORT_FD:
		begin
			porthit = 1'b1; // whole xxFD range is ours
			if (!addr[15])
				sel = SEL_7FFD;
		end
		PORT_F7:
		begin
			// eff7 hidden in shadow mode
			if (!shadow)
			begin
				porthit = 1'b1;
				if (addr[8] && !addr[12])
					sel = SEL_EFF7;
			end
		end
		SAV_BASE, SAV_BASE + 8'h20, SAV_BASE + 8'h40, SAV_BASE + 8'h60:
		begin
			if (shadow) // scratch ports only under shadow
			begin
				sel     = SEL_SAV;
				porthit = 1'b1;
			end
		end
		default: ;
		endcase
	end

endmodule

// File: verilog/read_mux.sv
// read data mux
// z80 read data for every readable port, BE readback and the bus drive enable
`timescale 1ns/1ps

module read_mux (
	input  zx_port_pkg::zbus_t     bus,
	input  zx_port_pkg::port_sel_e sel,
	input  logic                   porthit,
	input  logic [4:0]             keys_in,
	input  logic                   tape_read,
	input  zx_port_pkg::paging_t   paging,
	input  logic [7:0]             bf_value,
	input  logic [7:0]             sav_data,
	output logic [7:0]             dout,
	output logic                   dataout
);

	import zx_port_pkg::*;

	logic [7:0] be_data; // config readback

	always_comb
	begin
		case (bus.addr[11:8]) // index in high byte
		4'h0:    be_data = paging.rampage0;
		4'h1:    be_data = paging.rampage1;
		4'h2:    be_data = paging.rampage2;
		4'h3:    be_data = paging.rampage3;
		4'h4:    be_data = paging.vpage;
		4'hA:    be_data = paging.p7ffd;
		4'hB:    be_data = paging.peff7_raw; // raw, not masked
		default: be_data = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (sel)
		SEL_FE:  dout = {1'b1, tape_read, 1'b0, keys_in};
		SEL_BF:  dout = bf_value;
		SEL_SAV: dout = sav_data;
		SEL_BE:  dout = be_data;
		default: dout = 8'hFF; // open bus
		endcase
	end

	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n; // drive only on our reads

endmodule

// File: verilog/shadow_regs.sv
// shadow config port BF and the four scratch ports
// shadow mode comes from dos or the BF enable bit
`timescale 1ns/1ps

module shadow_regs (
	input  logic                           zclk,
	input  logic                           rst_n,
	input  zx_port_pkg::strobe_t           strobe,
	input  zx_port_pkg::port_sel_e         sel,
	input  logic [zx_port_pkg::ADDR_W-1:0] addr,
	input  logic [zx_port_pkg::DATA_W-1:0] din,
	input  logic                           dos,
	output logic                           shadow,
	output logic                           romrw_en,
	output logic [7:0]                     bf_value,
	output logic [7:0]                     sav_data
);

	import zx_port_pkg::*;

	logic       shadow_en;   // bit 0 of BF
	logic [7:0] savport [4]; // scratch storage, index addr[6:5]

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
		end
		else if (strobe.wr && sel == SEL_BF)
		begin
			shadow_en <= din[0];
			romrw_en  <= din[1]; // rom write enable
		end
	end

	always_ff @(posedge zclk)
		if (strobe.wr && sel == SEL_SAV) // decoder already checked shadow
			savport[addr[6:5]] <= din;

	assign shadow   = dos | shadow_en;
	assign bf_value = {6'b000000, romrw_en, shadow_en};
	assign sav_data = savport[addr[6:5]];

endmodule

// File: verilog/video_regs.sv
// video registers
// xxAF sub-registers for vconfig, fmaddr and offsets, plus the FE border
`timescale 1ns/1ps

module video_regs (
	input  logic                           zclk,
	input  logic                           rst_n,
	input  zx_port_pkg::strobe_t           strobe,
	input  zx_port_pkg::port_sel_e         sel,
	input  logic [zx_port_pkg::ADDR_W-1:0] addr,
	input  logic [zx_port_pkg::DATA_W-1:0] din,
	output zx_port_pkg::video_t            video
);

	import zx_port_pkg::*;

	logic    xt_wr; // xxAF write
	logic    fe_wr; // border write
	xt_reg_e xt_idx;

	assign xt_wr  = strobe.wr && (sel == SEL_XT);
	assign fe_wr  = strobe.wr && (sel == SEL_FE);
	assign xt_idx = xt_reg_e'(addr[15:8]); // high byte picks the register

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			video <= '0;
		else
		begin
			if (xt_wr)
			begin
				case (xt_idx)
				XT_VCONFIG: video.vconfig     <= din;
				XT_FMADDR:  video.fmaddr      <= din[4:0];
				XT_XOFFS_L: video.x_offs[7:0] <= din;
				XT_XOFFS_H: video.x_offs[8]   <= din[0]; // 9th bit only
				XT_YOFFS_L: video.y_offs[7:0] <= din;
				XT_YOFFS_H: video.y_offs[8]   <= din[0];
				default: ; // paging regs live elsewhere
				endcase
			end

			////////////////////
			// border on FE
			////////////////////
			if (fe_wr)
				video.border <= {din[7], din[2], din[1], din[0]};
		end
	end

endmodule

// File: verilog/zx_port_block.sv
// z80 i/o port block
// strobe sync, decoder, register files and read mux
`timescale 1ns/1ps

module zx_port_block (
	input  logic                 zclk,
	input  logic                 rst_n,
	input  zx_port_pkg::zbus_t   bus,
	input  logic                 dos,
	input  logic [4:0]           keys_in,
	input  logic                 tape_read,
	output logic [7:0]           dout,
	output logic                 dataout,
	output logic                 porthit,
	output zx_port_pkg::video_t  video,
	output zx_port_pkg::paging_t paging,
	output logic [7:0]           peff7,
	output logic                 pent1m_rom,
	output logic                 pent1m_1m_on,
	output logic                 romrw_en
);

	import zx_port_pkg::*;

	strobe_t    strobe;   // one-cycle wr/rd
	port_sel_e  sel;
	logic       shadow;
	logic [7:0] bf_value;
	logic [7:0] sav_data;

	io_strobe_sync io_strobe_sync_inst (.zclk(zclk), .rst_n(rst_n), .bus(bus), .strobe(strobe));

	port_decoder port_decoder_inst (.addr(bus.addr), .shadow(shadow), .sel(sel),
		.porthit(porthit));

	shadow_regs shadow_regs_inst (.zclk(zclk), .rst_n(rst_n), .strobe(strobe), .sel(sel),
		.addr(bus.addr), .din(bus.din), .dos(dos), .shadow(shadow), .romrw_en(romrw_en),
		.bf_value(bf_value), .sav_data(sav_data));

	video_regs video_regs_inst (.zclk(zclk), .rst_n(rst_n), .strobe(strobe), .sel(sel),
		.addr(bus.addr), .din(bus.din), .video(video));

	paging_regs paging_regs_inst (.zclk(zclk), .rst_n(rst_n), .strobe(strobe), .sel(sel),
		.addr(bus.addr), .din(bus.din), .paging(paging), .peff7(peff7),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on));

	read_mux read_mux_inst (.bus(bus), .sel(sel), .porthit(porthit), .keys_in(keys_in),
		.tape_read(tape_read), .paging(paging), .bf_value(bf_value), .sav_data(sav_data),
		.dout(dout), .dataout(dataout));

endmodule

// File: verilog/zx_port_pkg.sv
// zx port block shared definitions
// port map, xxAF sub-register numbers and bus/register structs
package zx_port_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// low address byte of each decoded port
	localparam logic [7:0] PORT_FE  = 8'hFE; // keyboard, tape, border
	localparam logic [7:0] PORT_XT  = 8'hAF; // extension port xxAF
	localparam logic [7:0] PORT_FD  = 8'hFD; // 7FFD paging
	localparam logic [7:0] PORT_F7  = 8'hF7; // EFF7 paging
	localparam logic [7:0] PORT_BE  = 8'hBE; // config readback
	localparam logic [7:0] PORT_BF  = 8'hBF; // shadow/romrw config
	localparam logic [7:0] SAV_BASE = 8'h2F; // scratch ports 2F/4F/6F/8F

	// which register file the current address hits
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_FE,
		SEL_XT,
		SEL_7FFD,
		SEL_EFF7,
		SEL_BE,
		SEL_BF,
		SEL_SAV
	} port_sel_e;

	// xxAF sub-register number, taken from the high address byte
	typedef enum logic [7:0] {
		XT_VCONFIG  = 8'd0,
		XT_VPAGE    = 8'd1,
		XT_XOFFS_L  = 8'd2,
		XT_XOFFS_H  = 8'd3,
		XT_YOFFS_L  = 8'd4,
		XT_YOFFS_H  = 8'd5,
		XT_RAMPAGE0 = 8'd16,
		XT_RAMPAGE1 = 8'd17,
		XT_RAMPAGE2 = 8'd18,
		XT_RAMPAGE3 = 8'd19,
		XT_FMADDR   = 8'd21
	} xt_reg_e;

	////////////////////
	// bus and register bundles
	////////////////////

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] din;
		logic              iorq_n;
		logic              rd_n;
		logic              wr_n;
	} zbus_t; // raw z80 side, 27 bits

	typedef struct packed {
		logic wr; // one-cycle port write
		logic rd; // one-cycle port read
	} strobe_t;

	typedef struct packed {
		logic [7:0] vconfig;
		logic [4:0] fmaddr;
		logic [8:0] x_offs;
		logic [8:0] y_offs;
		logic [3:0] border;
	} video_t; // 35 bits

	typedef struct packed {
		logic [7:0] vpage;
		logic [7:0] rampage0;
		logic [7:0] rampage1;
		logic [7:0] rampage2;
		logic [7:0] rampage3;
		logic [7:0] p7ffd;
		logic [7:0] peff7_raw; // unmasked eff7
	} paging_t; // 56 bits

endpackage

// File: zx_port_block.f
+incdir+bench
verilog/zx_port_pkg.sv
verilog/io_strobe_sync.sv
verilog/port_decoder.sv
verilog/shadow_regs.sv
verilog/video_regs.sv
verilog/paging_regs.sv
verilog/read_mux.sv
verilog/zx_port_block.sv
bench/zx_port_block_tb.sv
